//--- verification/lnk_golden.txt
# op  type|hdr  payload  answers  status  tries  deliver  (RECV gives the raw 8-bit header)
# answers per attempt: A ack, N nak, S stall, - none; status 1 ok, 2 failed, 3 timeout
SEND  D   deadbeef  A---  1  1  0
SEND  E   00c0ffee  NNA-  1  3  0
SEND  D   13572468  NNNN  2  4  0
SEND  E   a5a5a5a5  ----  3  1  0
RECV  2D  0badf00d  ----  0  0  1
RECV  3D  11111111  ----  0  0  0
SEND  0   00000000  SA--  1  2  0
RECV  1E  76543210  ----  0  0  1
RECV  0F  55aa55aa  ----  0  0  0
RECV  B4  9abcdef0  ----  0  0  0
SEND  3   ffffffff  NA--  1  2  0
SEND  D   01020304  NNN-  3  4  0
RECV  F0  00000001  ----  0  0  1
SEND  1   89abcdef  NNNA  1  4  0
RECV  E1  cafebabe  ----  0  0  1
SEND  2   0000ffff  N---  3  2  0

//--- lnk.f
+incdir+hw
hw/lnk_pkg.sv
hw/lnk_rx_decode.sv
hw/lnk_tx_frame.sv
hw/lnk_session.sv
hw/lnk_result.sv
hw/lnk_top.sv
verification/lnk_checker.sv
verification/lnk_tb.sv

//--- Bender.yml
package:
  name: lnk

export_include_dirs:
  - hw

sources:
  - hw/lnk_pkg.sv
  - hw/lnk_rx_decode.sv
  - hw/lnk_tx_frame.sv
  - hw/lnk_session.sv
  - hw/lnk_result.sv
  - hw/lnk_top.sv
  - target: test
    files:
      - verification/lnk_checker.sv
      - verification/lnk_tb.sv

//--- verification/lnk_tb.sv
`timescale 1ns/1ps
`include "lnk_consts.svh"

module lnk_tb;

    localparam int MAX_TESTS = 64;

    logic                  clk;
    logic                  rst;
    logic                  send_req;
    lnk_pkg::pkt_t         send_pkt;
    logic                  send_done;
    lnk_pkg::send_result_t send_result;
    logic                  read_valid;
    lnk_pkg::pkt_t         read_pkt;
    logic                  read_ack;
    logic                  tx_valid;
    lnk_pkg::frame_t       tx_frame;
    logic                  tx_ack;
    logic                  rx_valid;
    lnk_pkg::frame_t       rx_frame;
    logic                  rx_ack;
    lnk_pkg::link_stats_t  stats;

    // One entry per golden line.
    logic        g_send[MAX_TESTS];
    logic [7:0]  g_hdr[MAX_TESTS];
    logic [31:0] g_payload[MAX_TESTS];
    logic [31:0] g_script[MAX_TESTS];
    logic [1:0]  g_status[MAX_TESTS];
    logic [2:0]  g_tries[MAX_TESTS];
    logic        g_deliver[MAX_TESTS];
    int          n_tests;

    int                    test_num;
    logic                  is_send;
    logic [31:0]           cur_script;
    lnk_pkg::frame_t       exp_frame;
    lnk_pkg::send_result_t exp_result;
    logic                  exp_deliver;
    lnk_pkg::pkt_t         exp_read_pkt;
    int                    exp_frames;
    lnk_pkg::link_stats_t  exp_stats;
    logic                  test_end;
    logic                  final_check;
    int                    inject_count;
    lnk_pkg::frame_t       inject_frame;
    int                    pass_count;
    int                    fail_count;
    logic                  summary_done;

    lnk_top DUT (.*);

    lnk_checker u_checker (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic lnk_pkg::frame_t make_frame(input logic [3:0] t, input logic [31:0] p);
        lnk_pkg::frame_t f;
        f.hdr     = {~t, t};
        f.payload = p;
        return f;
    endfunction

    // Script letters: A is ACK, S is STALL, anything else NAK.
    function automatic logic [3:0] answer_type(input logic [7:0] c);
        if (c == "A") return lnk_pkg::ACK;
        else if (c == "S") return lnk_pkg::STALL;
        else return lnk_pkg::NAK;
    endfunction

    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_golden(output logic ok);
        int               fd;
        int               cnt;
        logic [8*120-1:0] line;
        logic [31:0]      op;
        logic [7:0]       hdr;
        logic [31:0]      payload;
        logic [31:0]      script;
        logic [3:0]       status;
        logic [3:0]       tries;
        logic [3:0]       deliver;
        ok = 1'b0;
        n_tests = 0;
        fd = $fopen("verification/lnk_golden.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                line = '0;
                cnt = $fgets(line, fd);
                cnt = $sscanf(line, "%s %h %h %s %h %h %h",
                              op, hdr, payload, script, status, tries, deliver);
                if (cnt == 7 && (op == "SEND" || op == "RECV")) begin
                    g_send[n_tests]    = (op == "SEND");
                    g_hdr[n_tests]     = hdr;
                    g_payload[n_tests] = payload;
                    g_script[n_tests]  = script;
                    g_status[n_tests]  = status[1:0];
                    g_tries[n_tests]   = tries[2:0];
                    g_deliver[n_tests] = deliver[0];
                    n_tests++;
                end
            end
            $fclose(fd);
            ok = (n_tests > 0);
        end
    endtask

    task automatic setup_test(input int i);
        @(negedge clk);
        test_num           = i;
        is_send            = g_send[i];
        cur_script         = g_script[i];
        exp_result.status  = lnk_pkg::send_status_e'(g_status[i]);
        exp_result.tries   = g_tries[i];
        exp_deliver        = g_deliver[i];
        exp_read_pkt.btype = lnk_pkg::btype_e'(g_hdr[i][3:0]);
        exp_read_pkt.payload = g_payload[i];
        if (g_send[i]) begin
            exp_frame  = make_frame(g_hdr[i][3:0], g_payload[i]);
            exp_frames = g_tries[i];
            if (g_status[i] == 2'd1) exp_stats.sends_ok = exp_stats.sends_ok + 1'b1;
            else exp_stats.sends_bad = exp_stats.sends_bad + 1'b1;
        end else begin
            // Answer frame is ACK for a deliverable packet, NAK otherwise.
            exp_frame  = make_frame(g_deliver[i] ? lnk_pkg::ACK : lnk_pkg::NAK, '0);
            exp_frames = 1;
            if (g_deliver[i]) exp_stats.rx_good = exp_stats.rx_good + 1'b1;
            else exp_stats.rx_rejected = exp_stats.rx_rejected + 1'b1;
        end
    endtask

    task automatic run_send(input int i);
        wait_cycle();
        send_pkt.btype   = lnk_pkg::btype_e'(g_hdr[i][3:0]);
        send_pkt.payload = g_payload[i];
        send_req         = 1'b1;
        do wait_cycle(); while (!send_done);
        send_req = 1'b0;
        do wait_cycle(); while (send_done);
    endtask

    task automatic run_recv(input int i);
        inject_frame = {g_hdr[i], g_payload[i]};
        inject_count = inject_count + 1;
        do wait_cycle(); while (!tx_valid);
        do wait_cycle(); while (tx_valid);
        if (g_deliver[i]) begin
            do wait_cycle(); while (!read_valid);
            read_ack = 1'b1;
            do wait_cycle(); while (read_valid);
            read_ack = 1'b0;
        end else begin
            // Quiet period in which read_valid must stay low.
            repeat (8) wait_cycle();
        end
    endtask

    task automatic end_test();
        wait_cycle();
        test_end = 1'b1;
        wait_cycle();
        test_end = 1'b0;
    endtask

    task automatic ack_tx();
        tx_ack = 1'b1;
        do wait_cycle(); while (tx_valid);
        tx_ack = 1'b0;
    endtask

    task automatic push_rx(input lnk_pkg::frame_t f);
        rx_frame = f;
        rx_valid = 1'b1;
        do wait_cycle(); while (!rx_ack);
        rx_valid = 1'b0;
        do wait_cycle(); while (rx_ack);
    endtask

    // Peer model.
    initial begin : peer_model
        int         inject_seen;
        int         attempt;
        int         last_test;
        logic [7:0] ans;
        void'($urandom(32'h6a08edb3));
        tx_ack      = 1'b0;
        rx_valid    = 1'b0;
        rx_frame    = '0;
        inject_seen = 0;
        attempt     = 0;
        last_test   = -1;
        forever begin
            wait_cycle();
            if (test_num != last_test) begin
                attempt   = 0;
                last_test = test_num;
            end
            if (inject_count != inject_seen) begin
                inject_seen = inject_count;
                push_rx(inject_frame);
            end else if (tx_valid) begin
                ack_tx();
                if (is_send && attempt < `LNK_RETRY_MAX) begin
                    ans = cur_script[31 - 8 * attempt -: 8];
                    attempt++;
                    if (ans != "-") begin
                        repeat (1 + $urandom % 20) @(posedge clk);
                        #1;
                        push_rx(make_frame(answer_type(ans), '0));
                    end
                end
            end
        end
    end

    initial begin : watchdog
        int unsigned limit;
        wait (n_tests > 0);
        limit = n_tests * `LNK_RETRY_MAX * (`LNK_TIMEOUT + 40);
        repeat (limit) @(posedge clk);
        $display("Run timed out after %0d cycles", limit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : host
        logic ok;
        rst          = 1'b1;
        send_req     = 1'b0;
        send_pkt     = '0;
        read_ack     = 1'b0;
        test_num     = -1;
        is_send      = 1'b0;
        cur_script   = "----";
        exp_frame    = '0;
        exp_result   = '0;
        exp_deliver  = 1'b0;
        exp_read_pkt = '0;
        exp_frames   = 0;
        exp_stats    = '0;
        test_end     = 1'b0;
        final_check  = 1'b0;
        inject_count = 0;
        inject_frame = '0;
        load_golden(ok);
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        if (!ok) begin
            $display("Golden file could not be read or holds no tests");
            $display("TEST FAILED");
            $finish;
        end else begin
            for (int i = 0; i < n_tests; i++) begin
                setup_test(i);
                if (g_send[i]) run_send(i);
                else run_recv(i);
                end_test();
            end
            wait_cycle();
            final_check = 1'b1;
            wait_cycle();
            final_check = 1'b0;
            do wait_cycle(); while (!summary_done);
            if (fail_count == 0 && pass_count == n_tests + 1) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

//--- verification/lnk_checker.sv
`timescale 1ns/1ps
`include "lnk_consts.svh"

module lnk_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  send_done,
    input  lnk_pkg::send_result_t send_result,
    input  logic                  read_valid,
    input  lnk_pkg::pkt_t         read_pkt,
    input  logic                  tx_valid,
    input  lnk_pkg::frame_t       tx_frame,
    input  lnk_pkg::link_stats_t  stats,
    input  int                    test_num,
    input  logic                  is_send,
    input  lnk_pkg::frame_t       exp_frame,
    input  lnk_pkg::send_result_t exp_result,
    input  logic                  exp_deliver,
    input  lnk_pkg::pkt_t         exp_read_pkt,
    input  int                    exp_frames,
    input  lnk_pkg::link_stats_t  exp_stats,
    input  logic                  test_end,
    input  logic                  final_check,
    output int                    pass_count,
    output int                    fail_count,
    output logic                  summary_done
);

    logic tx_valid_q;
    logic send_done_q;
    logic read_valid_q;
    int   frames;
    int   errors;

    function automatic int check_counter(input string name,
                                         input logic [`LNK_CNT_W-1:0] exp_v,
                                         input logic [`LNK_CNT_W-1:0] act_v);
        if (exp_v !== act_v) begin
            $display("Error: %s expected 0x%h, got 0x%h", name, exp_v, act_v);
            return 1;
        end
        return 0;
    endfunction

    // Sampled mid-cycle, where DUT outputs and stimulus are both settled.
    always @(negedge clk) begin
        if (rst) begin
            tx_valid_q = 1'b0;
            send_done_q = 1'b0;
            read_valid_q = 1'b0;
            frames = 0;
            errors = 0;
            pass_count = 0;
            fail_count = 0;
            summary_done = 1'b0;
        end else begin
            if (tx_valid && !tx_valid_q) begin
                frames++;
                if (tx_frame !== exp_frame) begin
                    $display("Error: tx_frame expected 0x%h, got 0x%h (test %0d)",
                             exp_frame, tx_frame, test_num);
                    errors++;
                end
            end
            if (send_done && !send_done_q) begin
                if (!is_send) begin
                    $display("Test %0d: send_done rose during a receive", test_num);
                    errors++;
                end else if (send_result !== exp_result) begin
                    $display("Error: send_result expected 0x%h, got 0x%h (test %0d)",
                             exp_result, send_result, test_num);
                    errors++;
                end
            end
            if (read_valid && !read_valid_q) begin
                if (is_send || !exp_deliver) begin
                    $display("Test %0d: a packet was delivered that should be dropped",
                             test_num);
                    errors++;
                end else if (read_pkt !== exp_read_pkt) begin
                    $display("Error: read_pkt expected 0x%h, got 0x%h (test %0d)",
                             exp_read_pkt, read_pkt, test_num);
                    errors++;
                end
            end
            if (test_end) begin
                if (frames != exp_frames) begin
                    $display("Test %0d: %0d frames were sent where %0d were expected",
                             test_num, frames, exp_frames);
                    errors++;
                end
                $display("test %0d %s %s", test_num, is_send ? "SEND" : "RECV",
                         errors == 0 ? "passed" : "failed");
                if (errors == 0) pass_count++;
                else fail_count++;
                frames = 0;
                errors = 0;
            end
            if (final_check) begin
                errors = check_counter("stats.sends_ok", exp_stats.sends_ok, stats.sends_ok)
                       + check_counter("stats.sends_bad", exp_stats.sends_bad, stats.sends_bad)
                       + check_counter("stats.rx_good", exp_stats.rx_good, stats.rx_good)
                       + check_counter("stats.rx_rejected", exp_stats.rx_rejected,
                                       stats.rx_rejected);
                $display("stats check %s", errors == 0 ? "passed" : "failed");
                if (errors == 0) pass_count++;
                else fail_count++;
                errors = 0;
                $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
                summary_done = 1'b1;
            end
            tx_valid_q = tx_valid;
            send_done_q = send_done;
            read_valid_q = read_valid;
        end
    end

endmodule

//--- hw/lnk_top.sv
`timescale 1ns/1ps

module lnk_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  send_req,
    input  lnk_pkg::pkt_t         send_pkt,
    output logic                  send_done,
    output lnk_pkg::send_result_t send_result,
    output logic                  read_valid,
    output lnk_pkg::pkt_t         read_pkt,
    input  logic                  read_ack,
    output logic                  tx_valid,
    output lnk_pkg::frame_t       tx_frame,
    input  logic                  tx_ack,
    input  logic                  rx_valid,
    input  lnk_pkg::frame_t       rx_frame,
    output logic                  rx_ack,
    output lnk_pkg::link_stats_t  stats
);

    lnk_pkg::pkt_t        rx_pkt;
    lnk_pkg::pkt_t        tx_pkt;
    logic                 tx_start;
    logic                 tx_busy;
    lnk_pkg::sess_event_t sess_evt;

    lnk_rx_decode u_rx_decode (
        .rx_frame (rx_frame),
        .rx_pkt   (rx_pkt)
    );

    lnk_session u_session (
        .clk        (clk),
        .rst        (rst),
        .send_req   (send_req),
        .send_pkt   (send_pkt),
        .send_done  (send_done),
        .read_valid (read_valid),
        .read_pkt   (read_pkt),
        .read_ack   (read_ack),
        .rx_valid   (rx_valid),
        .rx_pkt     (rx_pkt),
        .rx_ack     (rx_ack),
        .tx_start   (tx_start),
        .tx_pkt     (tx_pkt),
        .tx_busy    (tx_busy),
        .sess_evt   (sess_evt)
    );

    lnk_tx_frame u_tx_frame (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_pkt   (tx_pkt),
        .tx_busy  (tx_busy),
        .tx_valid (tx_valid),
        .tx_frame (tx_frame),
        .tx_ack   (tx_ack)
    );

    lnk_result u_result (
        .clk         (clk),
        .rst         (rst),
        .sess_evt    (sess_evt),
        .send_result (send_result),
        .stats       (stats)
    );

endmodule

//--- hw/lnk_result.sv
`timescale 1ns/1ps
`include "lnk_consts.svh"

module lnk_result (
    input  logic                  clk,
    input  logic                  rst,
    input  lnk_pkg::sess_event_t  sess_evt,
    output lnk_pkg::send_result_t send_result,
    output lnk_pkg::link_stats_t  stats
);

    // Counters stick at all ones.
    function automatic logic [`LNK_CNT_W-1:0] sat_inc(input logic [`LNK_CNT_W-1:0] v);
        return (&v) ? v : v + 1'b1;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            send_result.status <= lnk_pkg::NONE;
            send_result.tries  <= '0;
            stats              <= '0;
        end else if (sess_evt.valid) begin
            case (sess_evt.kind)
                lnk_pkg::EVT_SEND: begin
                    send_result.status <= sess_evt.status;
                    send_result.tries  <= sess_evt.tries;
                    if (sess_evt.status == lnk_pkg::OK) begin
                        stats.sends_ok <= sat_inc(stats.sends_ok);
                    end else begin
                        stats.sends_bad <= sat_inc(stats.sends_bad);
                    end
                end
                lnk_pkg::EVT_RX_GOOD: begin
                    stats.rx_good <= sat_inc(stats.rx_good);
                end
                lnk_pkg::EVT_RX_REJECTED: begin
                    stats.rx_rejected <= sat_inc(stats.rx_rejected);
                end
                default: ;
            endcase
        end
    end

    a_no_wrap: assert property (@(posedge clk) disable iff (rst)
        (stats.sends_ok >= $past(stats.sends_ok)) &&
        (stats.sends_bad >= $past(stats.sends_bad)) &&
        (stats.rx_good >= $past(stats.rx_good)) &&
        (stats.rx_rejected >= $past(stats.rx_rejected)));

endmodule

//--- hw/lnk_session.sv
`timescale 1ns/1ps
`include "lnk_consts.svh"

module lnk_session (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 send_req,
    input  lnk_pkg::pkt_t        send_pkt,
    output logic                 send_done,
    output logic                 read_valid,
    output lnk_pkg::pkt_t        read_pkt,
    input  logic                 read_ack,
    input  logic                 rx_valid,
    input  lnk_pkg::pkt_t        rx_pkt,
    output logic                 rx_ack,
    output logic                 tx_start,
    output lnk_pkg::pkt_t        tx_pkt,
    input  logic                 tx_busy,
    output lnk_pkg::sess_event_t sess_evt
);

    localparam int unsigned TIMEOUT = `LNK_TIMEOUT;
    localparam int TO_W = $clog2(TIMEOUT + 1);
    localparam logic [`LNK_TRY_W-1:0] RETRY_MAX = `LNK_RETRY_MAX;

    typedef enum logic [3:0] {
        IDLE,
        SEND_PREP,
        SEND_TX,
        ANS_WAIT,
        ANS_TAKE,
        SEND_DONE,
        READ_TAKE,
        READ_ANS,
        READ_DONE,
        RX_RELEASE
    } state_e;

    state_e                state;
    state_e                next_state;
    state_e                state_goto;
    logic [TO_W-1:0]       time_cnt;
    logic [`LNK_TRY_W-1:0] tx_cnt;
    logic                  rd_mode;
    lnk_pkg::send_status_e status_q;
    lnk_pkg::pkt_t         send_q;
    lnk_pkg::pkt_t         rd_pkt_q;
    logic                  timed_out;
    logic                  rd_good;

    assign timed_out = (state == ANS_WAIT) && !rx_valid && (time_cnt == TO_W'(TIMEOUT - 1));
    assign rd_good   = (rd_pkt_q.btype != lnk_pkg::ERROR);

    assign send_done  = (state == SEND_DONE);
    assign read_valid = (state == READ_DONE);
    assign rx_ack     = (state == RX_RELEASE);
    assign tx_start   = (state == SEND_PREP) || (state == READ_ANS);
    assign read_pkt   = rd_pkt_q;

    // Answer frames carry no payload.
    always_comb begin
        if (rd_mode) begin
            tx_pkt.btype   = rd_good ? lnk_pkg::ACK : lnk_pkg::NAK;
            tx_pkt.payload = '0;
        end else begin
            tx_pkt = send_q;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (send_req) next_state = SEND_PREP;
                else if (rx_valid) next_state = READ_TAKE;
            end
            SEND_PREP: next_state = SEND_TX;
            SEND_TX: begin
                if (!tx_busy) begin
                    if (!rd_mode) next_state = ANS_WAIT;
                    else if (rd_good) next_state = READ_DONE;
                    else next_state = IDLE;
                end
            end
            ANS_WAIT: begin
                if (rx_valid) next_state = ANS_TAKE;
                else if (timed_out) next_state = SEND_DONE;
            end
            ANS_TAKE:   next_state = RX_RELEASE;
            RX_RELEASE: if (!rx_valid) next_state = state_goto;
            SEND_DONE:  if (!send_req) next_state = IDLE;
            READ_TAKE:  next_state = RX_RELEASE;
            READ_ANS:   next_state = SEND_TX;
            READ_DONE:  if (read_ack) next_state = IDLE;
            default:    next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_goto <= IDLE;
            tx_cnt     <= '0;
            rd_mode    <= 1'b0;
            status_q   <= lnk_pkg::NONE;
        end else begin
            case (state)
                IDLE: begin
                    tx_cnt   <= '0;
                    status_q <= lnk_pkg::NONE;
                    if (send_req) rd_mode <= 1'b0;
                    else if (rx_valid) rd_mode <= 1'b1;
                end
                SEND_PREP: tx_cnt <= tx_cnt + 1'b1;
                ANS_TAKE: begin
                    // Anything other than ACK counts as NAK.
                    if (rx_pkt.btype == lnk_pkg::ACK) begin
                        status_q   <= lnk_pkg::OK;
                        state_goto <= SEND_DONE;
                    end else if (tx_cnt < RETRY_MAX) begin
                        state_goto <= SEND_PREP;
                    end else begin
                        status_q   <= lnk_pkg::FAILED;
                        state_goto <= SEND_DONE;
                    end
                end
                READ_TAKE: state_goto <= READ_ANS;
                default: ;
            endcase
        end
    end

    // Tx handshake time is not part of the answer window.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            time_cnt <= '0;
        end else if (state == ANS_WAIT && next_state == ANS_WAIT) begin
            time_cnt <= time_cnt + 1'b1;
        end else begin
            time_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && send_req) send_q <= send_pkt;
        if (state == READ_TAKE) rd_pkt_q <= rx_pkt;
    end

    // Event is valid in the last cycle before the outcome becomes visible.
    always_comb begin
        sess_evt = '0;
        if (timed_out) begin
            sess_evt.valid  = 1'b1;
            sess_evt.kind   = lnk_pkg::EVT_SEND;
            sess_evt.status = lnk_pkg::TIMEOUT;
            sess_evt.tries  = tx_cnt;
        end else if (state == RX_RELEASE && !rx_valid && state_goto == SEND_DONE) begin
            sess_evt.valid  = 1'b1;
            sess_evt.kind   = lnk_pkg::EVT_SEND;
            sess_evt.status = status_q;
            sess_evt.tries  = tx_cnt;
        end else if (state == SEND_TX && !tx_busy && rd_mode) begin
            sess_evt.valid = 1'b1;
            sess_evt.kind  = rd_good ? lnk_pkg::EVT_RX_GOOD : lnk_pkg::EVT_RX_REJECTED;
        end
    end

    a_done_read_excl: assert property (@(posedge clk) disable iff (rst)
        !(send_done && read_valid));

    a_timeout_bound: assert property (@(posedge clk) disable iff (rst)
        time_cnt <= TO_W'(TIMEOUT));

endmodule

//--- hw/lnk_tx_frame.sv
`timescale 1ns/1ps

module lnk_tx_frame (
    input  logic            clk,
    input  logic            rst,
    input  logic            tx_start,
    input  lnk_pkg::pkt_t   tx_pkt,
    output logic            tx_busy,
    output logic            tx_valid,
    output lnk_pkg::frame_t tx_frame,
    input  logic            tx_ack
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_REQ,
        TX_RELEASE
    } tx_state_e;

    tx_state_e state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= TX_IDLE;
        end else begin
            case (state)
                TX_IDLE:    if (tx_start) state <= TX_REQ;
                TX_REQ:     if (tx_ack) state <= TX_RELEASE;
                TX_RELEASE: if (!tx_ack) state <= TX_IDLE;
                default:    state <= TX_IDLE;
            endcase
        end
    end

    // Frame is captured once per start and held through the handshake.
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_start) begin
            tx_frame.hdr     <= {~tx_pkt.btype, tx_pkt.btype};
            tx_frame.payload <= tx_pkt.payload;
        end
    end

    assign tx_valid = (state == TX_REQ);
    assign tx_busy  = (state != TX_IDLE);

    a_frame_stable: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ack |=> $stable(tx_frame));

endmodule

//--- hw/lnk_rx_decode.sv
`timescale 1ns/1ps

module lnk_rx_decode (
    input  lnk_pkg::frame_t rx_frame,
    output lnk_pkg::pkt_t   rx_pkt
);

    logic [3:0] raw_type;
    logic       hdr_ok;
    logic       type_ok;

    assign raw_type = rx_frame.hdr[3:0];

    // High nibble must be the bitwise complement of the type.
    assign hdr_ok = (rx_frame.hdr[7:4] == ~raw_type);

    always_comb begin
        case (raw_type)
            lnk_pkg::INIT,
            lnk_pkg::ACK,
            lnk_pkg::NAK,
            lnk_pkg::STALL,
            lnk_pkg::DATA0,
            lnk_pkg::DATA1,
            lnk_pkg::ERROR: type_ok = 1'b1;
            default:        type_ok = 1'b0;
        endcase
    end

    always_comb begin
        if (hdr_ok && type_ok) begin
            rx_pkt.btype   = lnk_pkg::btype_e'(raw_type);
            rx_pkt.payload = rx_frame.payload;
        end else begin
            // Malformed header, payload is not trusted.
            rx_pkt.btype   = lnk_pkg::ERROR;
            rx_pkt.payload = '0;
        end
    end

endmodule

//--- hw/lnk_pkg.sv
`include "lnk_consts.svh"

package lnk_pkg;

    // Packet types on the link.
    typedef enum logic [3:0] {
        INIT  = 4'b0000,
        ACK   = 4'b0001,
        NAK   = 4'b0010,
        STALL = 4'b0011,
        DATA0 = 4'b1101,
        DATA1 = 4'b1110,
        ERROR = 4'b1111
    } btype_e;

    // Header high nibble carries the complement of the type in the low nibble.
    typedef struct packed {
        logic [7:0]  hdr;
        logic [31:0] payload;
    } frame_t;

    typedef struct packed {
        btype_e      btype;
        logic [31:0] payload;
    } pkt_t;

    typedef enum logic [1:0] {
        NONE    = 2'd0,
        OK      = 2'd1,
        FAILED  = 2'd2,
        TIMEOUT = 2'd3
    } send_status_e;

    typedef struct packed {
        send_status_e          status;
        logic [`LNK_TRY_W-1:0] tries;
    } send_result_t;

    typedef struct packed {
        logic [`LNK_CNT_W-1:0] sends_ok;
        logic [`LNK_CNT_W-1:0] sends_bad;
        logic [`LNK_CNT_W-1:0] rx_good;
        logic [`LNK_CNT_W-1:0] rx_rejected;
    } link_stats_t;

    typedef enum logic [1:0] {
        EVT_SEND        = 2'd0,
        EVT_RX_GOOD     = 2'd1,
        EVT_RX_REJECTED = 2'd2
    } evt_kind_e;

    typedef struct packed {
        logic                  valid;
        evt_kind_e             kind;
        send_status_e          status;
        logic [`LNK_TRY_W-1:0] tries;
    } sess_event_t;

endpackage

//--- hw/lnk_consts.svh
`ifndef LNK_CONSTS_SVH
`define LNK_CONSTS_SVH

// Cycles the session waits for the peer's answer after a transmission.
`define LNK_TIMEOUT 128

// Transmissions allowed per send, the first one included.
`define LNK_RETRY_MAX 4

// Width of the link event counters.
`define LNK_CNT_W 16

// Width of the transmission count reported per send.
`define LNK_TRY_W 3

`endif
